/* Makefile */
# Verilator flow for the SRIO DMA register block

VERILATOR  ?= verilator
TOP        ?= tb_srio_dma_ctrl
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0
SIM_FLAGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

/* axil_read_channel.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite read side, one read outstanding. Data is sampled on the
// ARREADY edge, so live inputs must be stable across that edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_read_channel #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  // Read address channel
  input  logic [addr_width-1:0]         s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  // Read data channel
  output logic [data_width-1:0]         s_axi_rdata,
  output srio_dma_ctrl_pkg::axi_resp_e  s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  // Register read port
  output srio_dma_ctrl_pkg::reg_sel_e   rd_sel,
  input  logic [data_width-1:0]         rd_data
);

  // Byte offset of a word within the address
  localparam int addr_lsb = $clog2(data_width / 8);

  srio_dma_ctrl_pkg::rd_state_e state_q;
  srio_dma_ctrl_pkg::reg_sel_e  sel_q;
  logic [data_width-1:0]        rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Channel FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state_q <= srio_dma_ctrl_pkg::R_IDLE;
      rdata_q <= '0;
    end
    else
    begin
      case (state_q)
        srio_dma_ctrl_pkg::R_IDLE:
          if (s_axi_arvalid)
            state_q <= srio_dma_ctrl_pkg::R_ACCEPT;
        // ARREADY edge, sample the bank
        srio_dma_ctrl_pkg::R_ACCEPT:
        begin
          rdata_q <= rd_data;
          state_q <= srio_dma_ctrl_pkg::R_DATA;
        end
        // Data and valid frozen until RREADY
        srio_dma_ctrl_pkg::R_DATA:
          if (s_axi_rready)
            state_q <= srio_dma_ctrl_pkg::R_IDLE;
        default:
          state_q <= srio_dma_ctrl_pkg::R_IDLE;
      endcase
    end
  end

  // Word index from the address
  always_ff @(posedge S_AXI_ACLK)
  begin
    if ((state_q == srio_dma_ctrl_pkg::R_IDLE) && s_axi_arvalid)
    begin
      sel_q <= srio_dma_ctrl_pkg::reg_sel_e'(
                 s_axi_araddr[addr_lsb +: srio_dma_ctrl_pkg::REG_SEL_BITS]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // One-cycle ARREADY, held low while data waits
  assign s_axi_arready = (state_q == srio_dma_ctrl_pkg::R_ACCEPT);
  assign s_axi_rvalid  = (state_q == srio_dma_ctrl_pkg::R_DATA);
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = srio_dma_ctrl_pkg::RESP_OKAY;
  assign rd_sel        = sel_q;

endmodule

/* axil_write_channel.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite write side, one write outstanding. Address and data must
// arrive together; addr_width has to reach the word index bits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_write_channel #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  // Write address channel
  input  logic [addr_width-1:0]         s_axi_awaddr,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  // Write data channel
  input  logic [data_width-1:0]         s_axi_wdata,
  input  logic [data_width/8-1:0]       s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  // Write response channel
  output srio_dma_ctrl_pkg::axi_resp_e  s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  // Register write port
  output logic                          wr_en,
  output srio_dma_ctrl_pkg::reg_sel_e   wr_sel,
  output logic [data_width-1:0]         wr_data,
  output logic [data_width/8-1:0]       wr_strb
);

  localparam int strb_width = data_width / 8;
  // Byte offset of a word, 2 for 32-bit and 3 for 64-bit buses
  localparam int addr_lsb = $clog2(strb_width);

  srio_dma_ctrl_pkg::wr_state_e state_q;
  srio_dma_ctrl_pkg::reg_sel_e  sel_q;
  logic [data_width-1:0]        data_q;
  logic [strb_width-1:0]        strb_q;
  logic                         req_seen;

  // Both halves of the write present
  assign req_seen = s_axi_awvalid && s_axi_wvalid;

  ////////////////////////////////////////////////////////////////////////////
  // Channel FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state_q <= srio_dma_ctrl_pkg::W_IDLE;
    end
    else
    begin
      case (state_q)
        srio_dma_ctrl_pkg::W_IDLE:
          if (req_seen)
            state_q <= srio_dma_ctrl_pkg::W_ACCEPT;
        // Handshake completes here, register write goes out
        srio_dma_ctrl_pkg::W_ACCEPT:
          state_q <= srio_dma_ctrl_pkg::W_RESP;
        // Hold the response until the master takes it
        srio_dma_ctrl_pkg::W_RESP:
          if (s_axi_bready)
            state_q <= srio_dma_ctrl_pkg::W_IDLE;
        default:
          state_q <= srio_dma_ctrl_pkg::W_IDLE;
      endcase
    end
  end

  // Capture address, data and strobes on the first edge both valids are seen
  always_ff @(posedge S_AXI_ACLK)
  begin
    if ((state_q == srio_dma_ctrl_pkg::W_IDLE) && req_seen)
    begin
      sel_q  <= srio_dma_ctrl_pkg::reg_sel_e'(
                  s_axi_awaddr[addr_lsb +: srio_dma_ctrl_pkg::REG_SEL_BITS]);
      data_q <= s_axi_wdata;
      strb_q <= s_axi_wstrb;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs decoded from state
  ////////////////////////////////////////////////////////////////////////////

  // Ready pulses for exactly one cycle, low while the response waits
  assign s_axi_awready = (state_q == srio_dma_ctrl_pkg::W_ACCEPT);
  assign s_axi_wready  = (state_q == srio_dma_ctrl_pkg::W_ACCEPT);
  assign s_axi_bvalid  = (state_q == srio_dma_ctrl_pkg::W_RESP);
  assign s_axi_bresp   = srio_dma_ctrl_pkg::RESP_OKAY;

  // Bank writes on the same edge that raises BVALID
  assign wr_en   = (state_q == srio_dma_ctrl_pkg::W_ACCEPT);
  assign wr_sel  = sel_q;
  assign wr_data = data_q;
  assign wr_strb = strb_q;

endmodule

/* build.f */
srio_dma_ctrl_pkg.sv
axil_write_channel.sv
ctrl_reg_bank.sv
axil_read_channel.sv
srio_dma_ctrl_top.sv
srio_dma_ctrl_assertions.sv
tb_srio_dma_ctrl.sv

/* ctrl_reg_bank.sv */
////////////////////////////////////////////////////////////////////////////
// Storage for cmd, num_pkts and three scratch words. Status and tuser_last
// are read live; writes to their slots and to slot 7 are dropped
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_reg_bank #(
  parameter int data_width = 32
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  // Write port from the write channel
  input  logic                          wr_en,
  input  srio_dma_ctrl_pkg::reg_sel_e   wr_sel,
  input  logic [data_width-1:0]         wr_data,
  input  logic [data_width/8-1:0]       wr_strb,
  // Read port, answered combinationally
  input  srio_dma_ctrl_pkg::reg_sel_e   rd_sel,
  output logic [data_width-1:0]         rd_data,
  // Splitter side
  input  logic [data_width-1:0]         status,
  input  logic [data_width-1:0]         tuser_last,
  output logic [data_width-1:0]         cmd,
  output logic [data_width-1:0]         num_pkts
);

  localparam int strb_width = data_width / 8;

  logic [data_width-1:0] cmd_q;
  logic [data_width-1:0] num_pkts_q;
  logic [data_width-1:0] scratch_q [3];
  logic [data_width-1:0] byte_mask;

  // Strobe bit per lane widened to a full byte
  always_comb
  begin
    for (int lane = 0; lane < strb_width; lane++)
    begin
      byte_mask[lane*8 +: 8] = {8{wr_strb[lane]}};
    end
  end

  // Keep old bytes where the mask is clear
  function automatic logic [data_width-1:0] merge_word(
    input logic [data_width-1:0] old_word,
    input logic [data_width-1:0] new_word,
    input logic [data_width-1:0] mask
  );
    merge_word = (old_word & ~mask) | (new_word & mask);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Writable words
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      cmd_q      <= '0;
      num_pkts_q <= '0;
      for (int i = 0; i < 3; i++)
      begin
        scratch_q[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      case (wr_sel)
        srio_dma_ctrl_pkg::REG_CMD:
          cmd_q <= merge_word(cmd_q, wr_data, byte_mask);
        srio_dma_ctrl_pkg::REG_NUM_PKTS:
          num_pkts_q <= merge_word(num_pkts_q, wr_data, byte_mask);
        srio_dma_ctrl_pkg::REG_SCRATCH0:
          scratch_q[0] <= merge_word(scratch_q[0], wr_data, byte_mask);
        srio_dma_ctrl_pkg::REG_SCRATCH1:
          scratch_q[1] <= merge_word(scratch_q[1], wr_data, byte_mask);
        srio_dma_ctrl_pkg::REG_SCRATCH2:
          scratch_q[2] <= merge_word(scratch_q[2], wr_data, byte_mask);
        // Status, tuser_last and the empty slot hold nothing
        default: ;
      endcase
    end
  end

  // Read select, slot 7 falls through to zero
  always_comb
  begin
    rd_data = '0;
    case (rd_sel)
      srio_dma_ctrl_pkg::REG_CMD:        rd_data = cmd_q;
      srio_dma_ctrl_pkg::REG_STATUS:     rd_data = status;
      srio_dma_ctrl_pkg::REG_NUM_PKTS:   rd_data = num_pkts_q;
      srio_dma_ctrl_pkg::REG_TUSER_LAST: rd_data = tuser_last;
      srio_dma_ctrl_pkg::REG_SCRATCH0:   rd_data = scratch_q[0];
      srio_dma_ctrl_pkg::REG_SCRATCH1:   rd_data = scratch_q[1];
      srio_dma_ctrl_pkg::REG_SCRATCH2:   rd_data = scratch_q[2];
      default:                           rd_data = '0;
    endcase
  end

  // Control words straight out to the splitter
  assign cmd      = cmd_q;
  assign num_pkts = num_pkts_q;

endmodule

/* srio_dma_ctrl_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite handshake checks for the register block top. Every check but
// the reset one is off while S_AXI_ARESETN is low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module srio_dma_ctrl_assertions #(
  parameter int data_width = 32
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  input  logic                          s_axi_awready,
  input  logic                          s_axi_wready,
  input  logic                          s_axi_arready,
  input  logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  input  logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  input  logic [data_width-1:0]         s_axi_rdata,
  input  srio_dma_ctrl_pkg::axi_resp_e  s_axi_bresp,
  input  srio_dma_ctrl_pkg::axi_resp_e  s_axi_rresp
);

  // Number of failed checks so far
  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Ready pulses
  ////////////////////////////////////////////////////////////////////////////

  // AWREADY and WREADY rise together and last one cycle
  aw_w_ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_awready || s_axi_wready) |=> !(s_axi_awready || s_axi_wready))
  else
  begin
    $error("AWREADY or WREADY high for two cycles in a row");
    fail_count++;
  end

  ar_ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_arready |=> !s_axi_arready)
  else
  begin
    $error("ARREADY high for two cycles in a row");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response channels
  ////////////////////////////////////////////////////////////////////////////

  // Valid stays up until the master takes it
  b_valid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
  else
  begin
    $error("BVALID dropped before BREADY");
    fail_count++;
  end

  r_valid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_rvalid && !s_axi_rready) |=> s_axi_rvalid)
  else
  begin
    $error("RVALID dropped before RREADY");
    fail_count++;
  end

  // Read data frozen while the master stalls
  r_data_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_rvalid && !s_axi_rready) |=> $stable(s_axi_rdata))
  else
  begin
    $error("RDATA changed while RVALID waited for RREADY");
    fail_count++;
  end

  resp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_bresp == srio_dma_ctrl_pkg::RESP_OKAY)
    && (s_axi_rresp == srio_dma_ctrl_pkg::RESP_OKAY))
  else
  begin
    $error("BRESP or RRESP is not OKAY");
    fail_count++;
  end

  // Synchronous reset, so readies are low from the cycle after a reset edge
  ready_in_reset: assert property (@(posedge S_AXI_ACLK)
    !S_AXI_ARESETN |=> !(s_axi_awready || s_axi_wready || s_axi_arready))
  else
  begin
    $error("A ready output was high during reset");
    fail_count++;
  end

endmodule

/* srio_dma_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the SRIO DMA splitter register block. Eight word slots
// are decoded, so the word index is fixed at three bits
////////////////////////////////////////////////////////////////////////////

package srio_dma_ctrl_pkg;

  // Width of the word index taken from the AXI address
  localparam int REG_SEL_BITS = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  // Word slots, numbered as seen on the bus
  typedef enum logic [REG_SEL_BITS-1:0] {
    REG_CMD        = 3'd0,
    REG_STATUS     = 3'd1,
    REG_NUM_PKTS   = 3'd2,
    REG_TUSER_LAST = 3'd3,
    REG_SCRATCH0   = 3'd4,
    REG_SCRATCH1   = 3'd5,
    REG_SCRATCH2   = 3'd6,
    REG_NONE       = 3'd7
  } reg_sel_e;

  // AXI response code, only OKAY is ever returned
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00
  } axi_resp_e;

  ////////////////////////////////////////////////////////////////////////////
  // Channel FSM states
  ////////////////////////////////////////////////////////////////////////////

  // Write side: wait, one-cycle accept, hold response
  typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_RESP} wr_state_e;

  // Read side: wait, one-cycle accept, hold data
  typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_DATA} rd_state_e;

endpackage

/* srio_dma_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// Register block top. For data_width 64 set addr_width to at least 6
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module srio_dma_ctrl_top #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  // AXI4-Lite write address
  input  logic [addr_width-1:0]         s_axi_awaddr,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  // AXI4-Lite write data
  input  logic [data_width-1:0]         s_axi_wdata,
  input  logic [data_width/8-1:0]       s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  // AXI4-Lite write response
  output srio_dma_ctrl_pkg::axi_resp_e  s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  // AXI4-Lite read address
  input  logic [addr_width-1:0]         s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  // AXI4-Lite read data
  output logic [data_width-1:0]         s_axi_rdata,
  output srio_dma_ctrl_pkg::axi_resp_e  s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  // Splitter control and status
  output logic [data_width-1:0]         cmd,
  output logic [data_width-1:0]         num_pkts,
  input  logic [data_width-1:0]         status,
  input  logic [data_width-1:0]         tuser_last
);

  // Write channel to bank
  logic                        wr_en;
  srio_dma_ctrl_pkg::reg_sel_e wr_sel;
  logic [data_width-1:0]       wr_data;
  logic [data_width/8-1:0]     wr_strb;

  // Read channel to bank
  srio_dma_ctrl_pkg::reg_sel_e rd_sel;
  logic [data_width-1:0]       rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  axil_write_channel #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_wr_chan (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .wr_en         (wr_en),
    .wr_sel        (wr_sel),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  ctrl_reg_bank #(
    .data_width (data_width)
  ) u_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_sel        (wr_sel),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_sel        (rd_sel),
    .rd_data       (rd_data),
    .status        (status),
    .tuser_last    (tuser_last),
    .cmd           (cmd),
    .num_pkts      (num_pkts)
  );

  axil_read_channel #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_rd_chan (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_sel        (rd_sel),
    .rd_data       (rd_data)
  );

endmodule

/* tb_srio_dma_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench at data_width 32 and addr_width 5. Data is checked here,
// handshakes by the bound assertion module u_protocol_checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_srio_dma_ctrl;

  localparam int data_width = 32;
  localparam int addr_width = 5;
  localparam int strb_width = data_width / 8;
  localparam int addr_lsb   = $clog2(strb_width);
  // About 800 transactions of up to 25 cycles each
  localparam int max_cycles = 800 * 25;

  logic                         S_AXI_ACLK;
  logic                         S_AXI_ARESETN;
  logic [addr_width-1:0]        s_axi_awaddr;
  logic                         s_axi_awvalid;
  logic                         s_axi_awready;
  logic [data_width-1:0]        s_axi_wdata;
  logic [strb_width-1:0]        s_axi_wstrb;
  logic                         s_axi_wvalid;
  logic                         s_axi_wready;
  srio_dma_ctrl_pkg::axi_resp_e s_axi_bresp;
  logic                         s_axi_bvalid;
  logic                         s_axi_bready;
  logic [addr_width-1:0]        s_axi_araddr;
  logic                         s_axi_arvalid;
  logic                         s_axi_arready;
  logic [data_width-1:0]        s_axi_rdata;
  srio_dma_ctrl_pkg::axi_resp_e s_axi_rresp;
  logic                         s_axi_rvalid;
  logic                         s_axi_rready;
  logic [data_width-1:0]        cmd;
  logic [data_width-1:0]        num_pkts;
  logic [data_width-1:0]        status;
  logic [data_width-1:0]        tuser_last;

  // Reference copy of the eight word slots
  logic [data_width-1:0] model [8];
  logic [31:0]           lcg_state = 32'hd8b0ab58;
  int                    cycle_count = 0;

  srio_dma_ctrl_top #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_dut (.*);

  bind srio_dma_ctrl_top srio_dma_ctrl_assertions #(
    .data_width (data_width)
  ) u_protocol_checks (.*);

  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic srio_dma_ctrl_pkg::reg_sel_e sel_of(input int i);
    return srio_dma_ctrl_pkg::reg_sel_e'(i[2:0]);
  endfunction

  // Only cmd, num_pkts and the scratch words hold data
  function automatic srio_dma_ctrl_pkg::reg_sel_e pick_writable();
    case ((lcg_next() >> 8) % 5)
      0:       return srio_dma_ctrl_pkg::REG_CMD;
      1:       return srio_dma_ctrl_pkg::REG_NUM_PKTS;
      2:       return srio_dma_ctrl_pkg::REG_SCRATCH0;
      3:       return srio_dma_ctrl_pkg::REG_SCRATCH1;
      default: return srio_dma_ctrl_pkg::REG_SCRATCH2;
    endcase
  endfunction

  function automatic srio_dma_ctrl_pkg::reg_sel_e pick_unwritable();
    case ((lcg_next() >> 8) % 3)
      0:       return srio_dma_ctrl_pkg::REG_STATUS;
      1:       return srio_dma_ctrl_pkg::REG_TUSER_LAST;
      default: return srio_dma_ctrl_pkg::REG_NONE;
    endcase
  endfunction

  // Byte lanes with a set strobe take the new data
  function automatic void model_write(input srio_dma_ctrl_pkg::reg_sel_e idx,
                                      input logic [data_width-1:0] data,
                                      input logic [strb_width-1:0] strb);
    if (idx inside {srio_dma_ctrl_pkg::REG_CMD, srio_dma_ctrl_pkg::REG_NUM_PKTS,
                    srio_dma_ctrl_pkg::REG_SCRATCH0, srio_dma_ctrl_pkg::REG_SCRATCH1,
                    srio_dma_ctrl_pkg::REG_SCRATCH2})
    begin
      for (int lane = 0; lane < strb_width; lane++)
      begin
        if (strb[lane])
          model[idx][lane*8 +: 8] = data[lane*8 +: 8];
      end
    end
  endfunction

  // Live inputs for slots 1 and 3, zero for slot 7
  function automatic logic [data_width-1:0] expected_word(
    input srio_dma_ctrl_pkg::reg_sel_e idx
  );
    case (idx)
      srio_dma_ctrl_pkg::REG_STATUS:     return status;
      srio_dma_ctrl_pkg::REG_TUSER_LAST: return tuser_last;
      srio_dma_ctrl_pkg::REG_NONE:       return '0;
      default:                           return model[idx];
    endcase
  endfunction

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic match_word(input string name, input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
    assert (actual === expected)
    else
      stop_on_failure($sformatf("Error: %s expected 0x%08h, got 0x%08h",
                                name, expected, actual));
  endtask

  task automatic expect_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected)
    else
      stop_on_failure($sformatf("Error: %s expected 0x%0h, got 0x%0h",
                                name, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus transactions
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_word(input srio_dma_ctrl_pkg::reg_sel_e idx,
                            input logic [data_width-1:0] data,
                            input logic [strb_width-1:0] strb, input int bdelay);
    @(posedge S_AXI_ACLK);
    s_axi_awaddr  <= addr_width'(idx) << addr_lsb;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_awready) @(negedge S_AXI_ACLK);
    expect_bit("s_axi_wready", 1'b1, s_axi_wready);
    // Handshake edge
    @(posedge S_AXI_ACLK);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    @(negedge S_AXI_ACLK);
    model_write(idx, data, strb);
    // BVALID one cycle after the ready pulse, outputs updated on that edge
    expect_bit("s_axi_bvalid", 1'b1, s_axi_bvalid);
    match_word("cmd", model[srio_dma_ctrl_pkg::REG_CMD], cmd);
    match_word("num_pkts", model[srio_dma_ctrl_pkg::REG_NUM_PKTS], num_pkts);
    repeat (bdelay)
    begin
      @(negedge S_AXI_ACLK);
      expect_bit("s_axi_bvalid", 1'b1, s_axi_bvalid);
      expect_bit("s_axi_awready", 1'b0, s_axi_awready);
    end
    @(posedge S_AXI_ACLK);
    s_axi_bready <= 1'b1;
    @(posedge S_AXI_ACLK);
    s_axi_bready <= 1'b0;
  endtask

  task automatic read_word(input srio_dma_ctrl_pkg::reg_sel_e idx, input int rdelay);
    logic [data_width-1:0] expected;
    @(posedge S_AXI_ACLK);
    s_axi_araddr  <= addr_width'(idx) << addr_lsb;
    s_axi_arvalid <= 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_arready) @(negedge S_AXI_ACLK);
    // Word as it stands across the ARREADY edge
    expected = expected_word(idx);
    @(posedge S_AXI_ACLK);
    s_axi_arvalid <= 1'b0;
    @(negedge S_AXI_ACLK);
    expect_bit("s_axi_rvalid", 1'b1, s_axi_rvalid);
    match_word("s_axi_rdata", expected, s_axi_rdata);
    repeat (rdelay)
    begin
      @(negedge S_AXI_ACLK);
      expect_bit("s_axi_rvalid", 1'b1, s_axi_rvalid);
      expect_bit("s_axi_arready", 1'b0, s_axi_arready);
      match_word("s_axi_rdata", expected, s_axi_rdata);
    end
    @(posedge S_AXI_ACLK);
    s_axi_rready <= 1'b1;
    @(posedge S_AXI_ACLK);
    s_axi_rready <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run limits
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge S_AXI_ACLK)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles)
      stop_on_failure("Timeout, the tests did not finish within the cycle limit");
  end

  always @(negedge S_AXI_ACLK)
  begin
    if (u_dut.u_protocol_checks.fail_count != 0)
      stop_on_failure("A protocol assertion on the AXI4-Lite port failed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    srio_dma_ctrl_pkg::reg_sel_e widx;
    srio_dma_ctrl_pkg::reg_sel_e ridx;
    logic [strb_width-1:0]       strb;
    logic [data_width-1:0]       wdata;
    int                          bdelay;
    int                          rdelay;
    S_AXI_ARESETN <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b0;
    s_axi_araddr  <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b0;
    status        <= '0;
    tuser_last    <= '0;
    for (int i = 0; i < 8; i++)
      model[i] = '0;
    repeat (16) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    // Reset state
    @(negedge S_AXI_ACLK);
    expect_bit("s_axi_awready", 1'b0, s_axi_awready);
    expect_bit("s_axi_wready", 1'b0, s_axi_wready);
    expect_bit("s_axi_arready", 1'b0, s_axi_arready);
    expect_bit("s_axi_bvalid", 1'b0, s_axi_bvalid);
    expect_bit("s_axi_rvalid", 1'b0, s_axi_rvalid);
    match_word("cmd", '0, cmd);
    match_word("num_pkts", '0, num_pkts);
    for (int i = 0; i < 8; i++)
      read_word(sel_of(i), 0);

    // Full words to every slot, then read back
    for (int i = 0; i < 8; i++)
      write_word(sel_of(i), lcg_next(), '1, 0);
    for (int i = 0; i < 8; i++)
      read_word(sel_of(i), 0);

    // Random byte strobes
    repeat (200)
    begin
      widx = pick_writable();
      strb = strb_width'(lcg_next() >> 12);
      write_word(widx, lcg_next(), strb, 0);
      read_word(widx, 0);
    end

    // Live inputs held across the reads, writes to slots 1, 3 and 7 dropped
    repeat (10)
    begin
      @(posedge S_AXI_ACLK);
      status     <= lcg_next();
      tuser_last <= lcg_next();
      read_word(srio_dma_ctrl_pkg::REG_STATUS, 0);
      read_word(srio_dma_ctrl_pkg::REG_TUSER_LAST, 0);
      strb = strb_width'(lcg_next() >> 12);
      write_word(pick_unwritable(), lcg_next(), strb, 0);
      // Every slot must be as before the dropped write
      for (int i = 0; i < 8; i++)
        read_word(sel_of(i), 0);
    end

    // Master stalls on BREADY and RREADY
    repeat (40)
    begin
      widx   = pick_writable();
      wdata  = lcg_next();
      bdelay = int'((lcg_next() >> 4) % 11);
      rdelay = int'((lcg_next() >> 4) % 11);
      write_word(widx, wdata, '1, bdelay);
      read_word(pick_writable(), rdelay);
    end

    // Write and read in the same cycles on different slots
    repeat (100)
    begin
      widx   = pick_writable();
      ridx   = sel_of(int'(lcg_next() >> 13));
      if (ridx == widx)
        ridx = srio_dma_ctrl_pkg::REG_NONE;
      strb   = strb_width'(lcg_next() >> 12);
      wdata  = lcg_next();
      bdelay = int'((lcg_next() >> 4) % 4);
      rdelay = int'((lcg_next() >> 4) % 4);
      fork
        write_word(widx, wdata, strb, bdelay);
        read_word(ridx, rdelay);
      join
    end

    // Past the last edge, so its assertion results are in
    @(negedge S_AXI_ACLK);
    if (u_dut.u_protocol_checks.fail_count != 0)
      stop_on_failure("A protocol assertion on the AXI4-Lite port failed");
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule
